// ==== project.f ====
+incdir+common
common/data_io_pkg.sv
common/dio_ctrl_if.sv
spi_link/spi_cmd_rx.sv
spi_link/spi_upload_tx.sv
verilog/sd_direct_rx.sv
verilog/ioctl_writer.sv
verilog/data_io.sv
verif/tb_clock.sv
verif/data_io_tb.sv

// ==== Bender.yml ====
package:
  name: data_io

sources:
  - include_dirs:
      - common
    files:
      - common/data_io_pkg.sv
      - common/dio_ctrl_if.sv
      - spi_link/spi_cmd_rx.sv
      - spi_link/spi_upload_tx.sv
      - verilog/sd_direct_rx.sv
      - verilog/ioctl_writer.sv
      - verilog/data_io.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/tb_clock.sv
      - verif/data_io_tb.sv

// ==== verif/data_io_tb.sv ====
`include "data_io_params.svh"

module data_io_tb;
	import data_io_pkg::*;

	localparam int N_DL = 40;
	localparam int N_UL = 8;
	localparam int FILE_SIZE = 600;
	// index, two directory entries, both runs with start and end, two sectors
	localparam int TOTAL_BITS = 16 + 2 * 33 * 8 + (N_DL + N_UL + 6) * 16
		+ 2 * `DIO_SECTOR_BYTES * 8;
	localparam int TOTAL_FRAMES = N_DL + N_UL + 10;
	// four closing cycles per frame plus reset, then slack
	localparam int WATCHDOG_T = (TOTAL_BITS + 4 * TOTAL_FRAMES + 2) * 4 + 1000;

	logic                   SPI_SCK;
	logic                   SPI_SS2;
	logic                   SPI_SS4;
	logic                   SPI_DI;
	wire                    SPI_DO;
	logic                   ioctl_download;
	logic                   ioctl_upload;
	logic [7:0]             ioctl_index;
	logic                   ioctl_wr;
	logic [`DIO_ADDR_W-1:0] ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic [7:0]             ioctl_din;
	logic [23:0]            ioctl_fileext;
	logic [31:0]            ioctl_filesize;
	// sd card model drive
	logic                   sd_oe;
	logic                   sd_bit;

	logic [31:0]            rng = 32'h13b1144b;
	string                  test_name;
	logic [7:0]             tx_buf [0:32];
	logic [7:0]             rx_buf [0:32];
	logic [7:0]             ent [0:31];
	logic [7:0]             exp_data [0:1023];
	// every ioctl_wr seen on the port
	logic [`DIO_ADDR_W-1:0] wr_addr_log [0:1023];
	logic [7:0]             wr_data_log [0:1023];
	int                     wr_cnt = 0;

	tb_clock #(.PERIOD(4)) clock_inst (.clk(SPI_SCK));

	data_io data_io_inst (
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (SPI_SS2),
		.SPI_SS4        (SPI_SS4),
		.SPI_DI         (SPI_DI),
		.SPI_DO         (SPI_DO),
		.ioctl_download (ioctl_download),
		.ioctl_upload   (ioctl_upload),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_din      (ioctl_din),
		.ioctl_fileext  (ioctl_fileext),
		.ioctl_filesize (ioctl_filesize)
	);

	// sd card shares the data-out line
	assign SPI_DO = sd_oe ? sd_bit : 1'bz;

	// memory read model, byte depends on the current address
	always @(posedge SPI_SCK)
		ioctl_din <= ioctl_addr[7:0] ^ 8'hA5;

	always @(posedge SPI_SCK) begin
		if (ioctl_wr === 1'b1 && wr_cnt < 1024) begin
			wr_addr_log[wr_cnt] = ioctl_addr;
			wr_data_log[wr_cnt] = ioctl_dout;
			wr_cnt = wr_cnt + 1;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		rng = xorshift(rng);
		b = rng[7:0];
	endtask

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// one byte on the command link, msb first
	task automatic spi_byte(input logic [7:0] b, output logic [7:0] r);
		int i;
		for (i = 7; i >= 0; i--) begin
			@(posedge SPI_SCK);
			SPI_SS2 <= 1'b0;
			SPI_DI  <= b[i];
			// data out moves on the falling edge, look just after it
			@(negedge SPI_SCK);
			#1;
			r[i] = SPI_DO;
		end
	endtask

	// select stays low two cycles past the last bit for the pending write
	task automatic spi_frame(input int len);
		int j;
		logic [7:0] r;
		for (j = 0; j < len; j++) begin
			spi_byte(tx_buf[j], r);
			rx_buf[j] = r;
		end
		repeat (3) @(posedge SPI_SCK);
		SPI_SS2 <= 1'b1;
		@(negedge SPI_SCK);
	endtask

	task automatic send_cmd(input logic [7:0] op, input logic [7:0] d);
		tx_buf[0] = op;
		tx_buf[1] = d;
		spi_frame(2);
	endtask

	task automatic sd_byte(input logic [7:0] d);
		int i;
		for (i = 7; i >= 0; i--) begin
			@(posedge SPI_SCK);
			SPI_SS4 <= 1'b0;
			sd_oe   <= 1'b1;
			sd_bit  <= d[i];
		end
	endtask

	// 32 random entry bytes, size field optionally forced
	task automatic send_direntry(input logic set_size, input logic [31:0] size);
		int j;
		logic [7:0] d;
		for (j = 0; j < 32; j++) begin
			rand_byte(d);
			ent[j] = d;
		end
		if (set_size) begin
			ent[28] = size[7:0];
			ent[29] = size[15:8];
			ent[30] = size[23:16];
			ent[31] = size[31:24];
		end
		tx_buf[0] = DIO_FILE_INFO;
		for (j = 0; j < 32; j++)
			tx_buf[j + 1] = ent[j];
		spi_frame(33);
	endtask

	task automatic test_reset();
		test_name = "reset";
		check_eq("ioctl_wr", 32'd0, ioctl_wr);
		check_eq("SPI_DO", 1'bz, SPI_DO);
	endtask

	task automatic test_index();
		logic [7:0] d;
		test_name = "index";
		rand_byte(d);
		send_cmd(DIO_FILE_INDEX, d);
		check_eq("ioctl_index", d, ioctl_index);
	endtask

	task automatic test_direntry();
		test_name = "direntry";
		send_direntry(1'b0, 32'd0);
		check_eq("ioctl_fileext", {ent[8], ent[9], ent[10]}, ioctl_fileext);
		check_eq("ioctl_filesize", {ent[31], ent[30], ent[29], ent[28]}, ioctl_filesize);
	endtask

	task automatic test_download();
		int k;
		logic [7:0] d;
		test_name = "download";
		wr_cnt = 0;
		send_cmd(DIO_FILE_TX, 8'h01);
		check_eq("ioctl_download", 32'd1, ioctl_download);
		for (k = 0; k < N_DL; k++) begin
			rand_byte(d);
			exp_data[k] = d;
			send_cmd(DIO_FILE_TX_DAT, d);
			check_eq("ioctl_download", 32'd1, ioctl_download);
		end
		send_cmd(DIO_FILE_TX, 8'h00);
		check_eq("ioctl_download", 32'd0, ioctl_download);
		check_eq("write count", N_DL, wr_cnt);
		for (k = 0; k < N_DL; k++) begin
			check_eq("write address", `DIO_START_ADDR + k, wr_addr_log[k]);
			check_eq("write data", exp_data[k], wr_data_log[k]);
		end
	endtask

	task automatic test_upload();
		int k;
		logic [7:0] a;
		test_name = "upload";
		wr_cnt = 0;
		send_cmd(DIO_FILE_RX, 8'h01);
		check_eq("ioctl_upload", 32'd1, ioctl_upload);
		check_eq("ioctl_addr", `DIO_START_ADDR, ioctl_addr);
		for (k = 0; k < N_UL; k++) begin
			send_cmd(DIO_FILE_RX_DAT, 8'h00);
			a = 8'(`DIO_START_ADDR + k);
			check_eq("returned byte", a ^ 8'hA5, rx_buf[1]);
			check_eq("ioctl_addr", `DIO_START_ADDR + k + 1, ioctl_addr);
		end
		send_cmd(DIO_FILE_RX, 8'h00);
		check_eq("ioctl_upload", 32'd0, ioctl_upload);
		check_eq("write count", 32'd0, wr_cnt);
	endtask

	task automatic test_direct();
		int s;
		int b;
		int k;
		logic [7:0] d;
		test_name = "direct";
		send_direntry(1'b1, FILE_SIZE);
		check_eq("ioctl_filesize", FILE_SIZE, ioctl_filesize);
		send_cmd(DIO_FILE_TX, 8'h01);
		wr_cnt = 0;
		// crc pair at the end of each sector is random too
		for (s = 0; s < 2; s++) begin
			for (b = 0; b < `DIO_SECTOR_BYTES; b++) begin
				rand_byte(d);
				if (b < `DIO_SECTOR_DATA)
					exp_data[s * `DIO_SECTOR_DATA + b] = d;
				sd_byte(d);
			end
		end
		repeat (3) @(posedge SPI_SCK);
		SPI_SS4 <= 1'b1;
		sd_oe   <= 1'b0;
		@(negedge SPI_SCK);
		send_cmd(DIO_FILE_TX, 8'h00);
		check_eq("write count", FILE_SIZE, wr_cnt);
		for (k = 0; k < FILE_SIZE; k++) begin
			check_eq("write address", `DIO_START_ADDR + k, wr_addr_log[k]);
			check_eq("write data", exp_data[k], wr_data_log[k]);
		end
	endtask

	initial begin
		#(WATCHDOG_T);
		$display("watchdog expired before the tests finished");
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		SPI_SS2   = 1'b1;
		SPI_SS4   = 1'b1;
		SPI_DI    = 1'b0;
		ioctl_din = 8'd0;
		sd_oe     = 1'b0;
		sd_bit    = 1'b0;
		// both selects high hold every counter cleared
		repeat (2) @(posedge SPI_SCK);
		@(negedge SPI_SCK);
		test_reset();
		test_index();
		test_direntry();
		test_download();
		test_upload();
		test_direct();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	// free running, starts low
	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== verilog/data_io.sv ====
`include "data_io_params.svh"

module data_io (
	input  logic                   SPI_SCK,
	input  logic                   SPI_SS2,
	input  logic                   SPI_SS4,
	input  logic                   SPI_DI,
	inout  wire                    SPI_DO,
	output logic                   ioctl_download,
	output logic                   ioctl_upload,
	output logic [7:0]             ioctl_index,
	output logic                   ioctl_wr,
	output logic [`DIO_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]             ioctl_dout,
	input  logic [7:0]             ioctl_din,
	output logic [23:0]            ioctl_fileext,
	output logic [31:0]            ioctl_filesize
);

	// command receiver to write stage
	dio_ctrl_if ctrl_bus ();

	logic       tx_sdo;
	logic       tx_oe;
	logic       sector_stb;
	logic [7:0] sector_byte;
	// write stage idles only when neither link is selected
	logic       wr_rst;

	// released whenever the command link is deselected
	assign SPI_DO = tx_oe ? tx_sdo : 1'bz;
	assign wr_rst = SPI_SS2 & SPI_SS4;

	spi_cmd_rx cmd_rx_inst (
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (SPI_SS2),
		.SPI_DI         (SPI_DI),
		.ctrl           (ctrl_bus.rx),
		.ioctl_index    (ioctl_index),
		.ioctl_fileext  (ioctl_fileext),
		.ioctl_filesize (ioctl_filesize)
	);

	spi_upload_tx upload_tx_inst (
		.SPI_SCK   (SPI_SCK),
		.SPI_SS2   (SPI_SS2),
		.ioctl_din (ioctl_din),
		.sdo       (tx_sdo),
		.sdo_oe    (tx_oe)
	);

	// sd card shares the data-out line with the transmitter
	sd_direct_rx direct_rx_inst (
		.SPI_SCK     (SPI_SCK),
		.SPI_SS4     (SPI_SS4),
		.sd_di       (SPI_DO),
		.sector_stb  (sector_stb),
		.sector_byte (sector_byte)
	);

	ioctl_writer writer_inst (
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (wr_rst),
		.ctrl           (ctrl_bus.wr),
		.sector_stb     (sector_stb),
		.sector_byte    (sector_byte),
		.filesize       (ioctl_filesize),
		.ioctl_download (ioctl_download),
		.ioctl_upload   (ioctl_upload),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// ==== verilog/ioctl_writer.sv ====
`include "data_io_params.svh"

module ioctl_writer (
	input  logic                   SPI_SCK,
	input  logic                   SPI_SS2,
	dio_ctrl_if.wr                 ctrl,
	input  logic                   sector_stb,
	input  logic [7:0]             sector_byte,
	input  logic [31:0]            filesize,
	output logic                   ioctl_download,
	output logic                   ioctl_upload,
	output logic                   ioctl_wr,
	output logic [`DIO_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]             ioctl_dout
);

	localparam logic [`DIO_ADDR_W-1:0] START = `DIO_ADDR_W'(`DIO_START_ADDR);

	// download byte from the command link
	logic                   cmd_wr;
	// upload read request
	logic                   cmd_rd;
	// direct byte still inside the file
	logic                   direct_acc;
	// direct byte parked for one cycle after a collision
	logic                   hold_valid;
	logic [7:0]             hold_byte;
	logic                   do_write;
	logic [7:0]             wr_byte;
	logic                   wr_r;
	logic [7:0]             dout_r;

	// session state, reloaded at each transfer start
	logic [`DIO_ADDR_W-1:0] wr_addr    = START;
	logic [`DIO_ADDR_W-1:0] addr_r     = START;
	logic [31:0]            filepos    = 32'd0;
	logic                   download_r = 1'b0;
	logic                   upload_r   = 1'b0;

	assign cmd_wr     = ctrl.data_stb & ctrl.download;
	assign cmd_rd     = ctrl.data_stb & ctrl.upload;
	assign direct_acc = sector_stb && (filepos < filesize);
	assign do_write   = cmd_wr | hold_valid | direct_acc;

	// command link wins, then a parked direct byte, then a fresh one
	always_comb begin
		if (cmd_wr)
			wr_byte = ctrl.data;
		else if (hold_valid)
			wr_byte = hold_byte;
		else
			wr_byte = sector_byte;
	end

	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			wr_r       <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			wr_r       <= do_write;
			hold_valid <= cmd_wr & direct_acc;
		end
	end

	always_ff @(posedge SPI_SCK) begin
		if (cmd_wr && direct_acc)
			hold_byte <= sector_byte;
		if (do_write) begin
			dout_r  <= wr_byte;
			addr_r  <= wr_addr;
			wr_addr <= wr_addr + 1'b1;
		end
		// upload only steps the read address
		if (cmd_rd)
			addr_r <= addr_r + 1'b1;
		if (direct_acc)
			filepos <= filepos + 32'd1;
		if (!ctrl.download)
			download_r <= 1'b0;
		if (!ctrl.upload)
			upload_r <= 1'b0;
		// new transfer, back to the start address
		if (ctrl.xfer_start) begin
			wr_addr    <= START;
			addr_r     <= START;
			filepos    <= 32'd0;
			download_r <= ctrl.download;
			upload_r   <= ctrl.upload;
		end
	end

	assign ioctl_wr       = wr_r;
	assign ioctl_dout     = dout_r;
	assign ioctl_addr     = addr_r;
	assign ioctl_download = download_r;
	assign ioctl_upload   = upload_r;

endmodule

// ==== verilog/sd_direct_rx.sv ====
`include "data_io_params.svh"

module sd_direct_rx (
	input  logic       SPI_SCK,
	input  logic       SPI_SS4,
	input  logic       sd_di,
	output logic       sector_stb,
	output logic [7:0] sector_byte
);

	localparam int BYTE_W = $clog2(`DIO_SECTOR_BYTES);

	// bit inside the byte
	logic [2:0]        bit_cnt;
	// byte inside the sector, crc bytes included
	logic [BYTE_W-1:0] byte_cnt;
	logic [6:0]        sbuf;
	logic              byte_done;
	// low for the two crc bytes at the end of a sector
	logic              in_data;

	assign byte_done = (bit_cnt == 3'd7);
	assign in_data   = (byte_cnt < BYTE_W'(`DIO_SECTOR_DATA));

	// counters and strobe, cleared while the sd select is high
	always_ff @(posedge SPI_SCK or posedge SPI_SS4) begin
		if (SPI_SS4) begin
			bit_cnt    <= 3'd0;
			byte_cnt   <= '0;
			sector_stb <= 1'b0;
		end else begin
			sector_stb <= 1'b0;
			bit_cnt    <= bit_cnt + 3'd1;
			if (byte_done) begin
				// wrap at the end of each sector
				if (byte_cnt == BYTE_W'(`DIO_SECTOR_BYTES - 1))
					byte_cnt <= '0;
				else
					byte_cnt <= byte_cnt + 1'b1;
				// crc bytes are swallowed here
				sector_stb <= in_data;
			end
		end
	end

	// the card drives the data line directly
	always_ff @(posedge SPI_SCK) begin
		sbuf <= {sbuf[5:0], sd_di};
		if (byte_done && in_data)
			sector_byte <= {sbuf, sd_di};
	end

endmodule

// ==== spi_link/spi_upload_tx.sv ====
module spi_upload_tx (
	input  logic       SPI_SCK,
	input  logic       SPI_SS2,
	input  logic [7:0] ioctl_din,
	output logic       sdo,
	output logic       sdo_oe
);
	import data_io_pkg::*;

	// bits already sampled by the receiver in the current byte
	logic [2:0]   bit_cnt;
	frame_phase_e phase;
	// byte being returned to the controller
	logic [7:0]   shreg;
	logic         oe_r;

	// falling edge control, frame reset on the select
	always_ff @(negedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			bit_cnt <= 3'd0;
			phase   <= PHASE_CMD;
			oe_r    <= 1'b0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7)
				phase <= PHASE_DATA;
			// drive from the first bit of the first data byte
			oe_r <= (phase == PHASE_DATA);
		end
	end

	// grab the next byte while its predecessor sends the last bit
	always_ff @(negedge SPI_SCK) begin
		if (bit_cnt == 3'd7)
			shreg <= ioctl_din;
		// msb first
		sdo <= shreg[~bit_cnt];
	end

	assign sdo_oe = oe_r;

endmodule

// ==== spi_link/spi_cmd_rx.sv ====
module spi_cmd_rx (
	input  logic        SPI_SCK,
	input  logic        SPI_SS2,
	input  logic        SPI_DI,
	dio_ctrl_if.rx      ctrl,
	output logic [7:0]  ioctl_index,
	output logic [23:0] ioctl_fileext,
	output logic [31:0] ioctl_filesize
);
	import data_io_pkg::*;

	// bit position, 0-7 opcode, then 8-15 for every data byte
	logic [3:0]   cnt;
	// first seven bits of the current byte
	logic [6:0]   sbuf;
	// full byte, the last bit taken straight from the line
	logic [7:0]   rx_byte;
	frame_phase_e phase;
	logic         op_done;
	logic         byte_done;
	// opcode of the running frame
	dio_cmd_e     cmd;
	// byte position inside a directory entry
	logic [4:0]   ent_cnt;

	logic         xfer_start_r;
	logic         data_stb_r;
	logic [7:0]   data_r;

	// session state, lives across many frames
	logic         download_r = 1'b0;
	logic         upload_r   = 1'b0;
	logic [7:0]   index_r    = 8'd0;
	logic [23:0]  fileext_r  = 24'd0;
	logic [31:0]  filesize_r = 32'd0;

	assign rx_byte   = {sbuf, SPI_DI};
	assign phase     = frame_phase_e'(cnt[3]);
	assign op_done   = (phase == PHASE_CMD) && (cnt[2:0] == 3'd7);
	assign byte_done = (phase == PHASE_DATA) && (cnt[2:0] == 3'd7);

	// frame control, cleared whenever the select goes high
	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			cnt          <= 4'd0;
			ent_cnt      <= 5'd0;
			xfer_start_r <= 1'b0;
			data_stb_r   <= 1'b0;
		end else begin
			xfer_start_r <= 1'b0;
			data_stb_r   <= 1'b0;
			// count 0-7 once, then 8-15 for the rest of the frame
			if (cnt == 4'd15)
				cnt <= 4'd8;
			else
				cnt <= cnt + 4'd1;
			if (byte_done) begin
				case (cmd)
					// opening a session restarts the addresses
					DIO_FILE_TX,
					DIO_FILE_RX:     xfer_start_r <= SPI_DI;
					DIO_FILE_TX_DAT,
					DIO_FILE_RX_DAT: data_stb_r <= 1'b1;
					DIO_FILE_INFO:   ent_cnt <= ent_cnt + 5'd1;
					default: ;
				endcase
			end
		end
	end

	// shift path and session registers
	always_ff @(posedge SPI_SCK) begin
		sbuf <= rx_byte[6:0];
		if (op_done)
			cmd <= dio_cmd_e'(rx_byte);
		if (byte_done) begin
			case (cmd)
				// bit 0 opens or closes the session
				DIO_FILE_TX:     download_r <= SPI_DI;
				DIO_FILE_RX:     upload_r <= SPI_DI;
				DIO_FILE_TX_DAT,
				DIO_FILE_RX_DAT: data_r <= rx_byte;
				DIO_FILE_INDEX:  index_r <= rx_byte;
				DIO_FILE_INFO: begin
					// extension msb first, size lsb first (fat direntry layout)
					case (ent_cnt)
						5'd8:  fileext_r[23:16]  <= rx_byte;
						5'd9:  fileext_r[15:8]   <= rx_byte;
						5'd10: fileext_r[7:0]    <= rx_byte;
						5'd28: filesize_r[7:0]   <= rx_byte;
						5'd29: filesize_r[15:8]  <= rx_byte;
						5'd30: filesize_r[23:16] <= rx_byte;
						5'd31: filesize_r[31:24] <= rx_byte;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	assign ctrl.xfer_start = xfer_start_r;
	assign ctrl.download   = download_r;
	assign ctrl.upload     = upload_r;
	assign ctrl.data_stb   = data_stb_r;
	assign ctrl.data       = data_r;

	assign ioctl_index    = index_r;
	assign ioctl_fileext  = fileext_r;
	assign ioctl_filesize = filesize_r;

endmodule

// ==== common/dio_ctrl_if.sv ====
interface dio_ctrl_if;

	// one cycle pulse when a download or upload is opened
	logic       xfer_start;
	// session levels
	logic       download;
	logic       upload;
	// one cycle pulse per completed data byte
	logic       data_stb;
	// byte that goes with data_stb
	logic [7:0] data;

	// command receiver side
	modport rx (
		output xfer_start,
		output download,
		output upload,
		output data_stb,
		output data
	);

	// write stage side, no back-pressure
	modport wr (
		input xfer_start,
		input download,
		input upload,
		input data_stb,
		input data
	);

endinterface

// ==== common/data_io_pkg.sv ====
package data_io_pkg;

	// command opcodes sent by the io controller as the first byte of a frame
	typedef enum logic [7:0] {
		// open or close a download, bit 0 of the data byte selects which
		DIO_FILE_TX     = 8'h53,
		// one download byte
		DIO_FILE_TX_DAT = 8'h54,
		// menu index of the file
		DIO_FILE_INDEX  = 8'h55,
		// 32-byte FAT directory entry
		DIO_FILE_INFO   = 8'h56,
		// open or close an upload
		DIO_FILE_RX     = 8'h57,
		// request the next upload byte
		DIO_FILE_RX_DAT = 8'h58
	} dio_cmd_e;

	// position inside a command-link frame
	typedef enum logic {
		// first byte, the opcode
		PHASE_CMD  = 1'b0,
		// every byte after the opcode
		PHASE_DATA = 1'b1
	} frame_phase_e;

endpackage

// ==== common/data_io_params.svh ====
`ifndef DATA_IO_PARAMS_SVH
`define DATA_IO_PARAMS_SVH

// width of the memory write address
`define DIO_ADDR_W 25

// first address of every transfer
`define DIO_START_ADDR 0

// sd sector as it arrives on the direct link, crc included
`define DIO_SECTOR_BYTES 514

// payload part of a sector, the two crc bytes follow it
`define DIO_SECTOR_DATA 512

`endif
